//--- color_store.sv
// Color buffer memory
// 256 RGB666 words with scissor test, per-channel write mask and 8 to 6 bit reduction
`timescale 1ns/10ps
`default_nettype none

module color_store (
    input  wire                        aclk,
    input  wire fb_cmd_pkg::fb_cfg_t   cfg,
    input  wire fb_cmd_pkg::fb_wr_t    wr,
    input  wire fb_cfg_pkg::fb_addr_t  rd_addr,
    output fb_cfg_pkg::fb_pixel_t      rd_data
);
    import fb_cfg_pkg::*;
    import fb_cmd_pkg::*;

    fb_pixel_t mem [FB_WORDS];

    fb_addr_t  wr_addr;
    fb_pixel_t wr_pixel;
    logic      in_x;
    logic      in_y;
    logic      in_scissor;
    logic      we_r;
    logic      we_g;
    logic      we_b;

    // Keep the upper bits of a pipeline channel
    function automatic logic [FB_SUB_PIXEL_WIDTH - 1 : 0] reduce(
        input logic [COLOR_SUB_PIXEL_WIDTH - 1 : 0] v
    );
        return v[COLOR_SUB_PIXEL_WIDTH - 1 -: FB_SUB_PIXEL_WIDTH];
    endfunction

    assign wr_addr = {wr.y, wr.x};

    // Row-major index matches the read-out order
    assign wr_pixel.r = reduce(wr.color.r);
    assign wr_pixel.g = reduce(wr.color.g);
    assign wr_pixel.b = reduce(wr.color.b);

    // Scissor end coordinates are exclusive
    assign in_x = (SCISSOR_POS_BITS'(wr.x) >= cfg.scissor.start_x)
               && (SCISSOR_POS_BITS'(wr.x) < cfg.scissor.end_x);
    assign in_y = (SCISSOR_POS_BITS'(wr.y) >= cfg.scissor.start_y)
               && (SCISSOR_POS_BITS'(wr.y) < cfg.scissor.end_y);
    assign in_scissor = !cfg.scissor_en || (in_x && in_y);

    // Lane enables, alpha has no storage
    assign we_r = wr.valid && in_scissor && cfg.mask.r;
    assign we_g = wr.valid && in_scissor && cfg.mask.g;
    assign we_b = wr.valid && in_scissor && cfg.mask.b;

    // Masked lanes keep the old value
    always_ff @(posedge aclk)
    begin
        if (we_r)
        begin
            mem[wr_addr].r <= wr_pixel.r;
        end
        if (we_g)
        begin
            mem[wr_addr].g <= wr_pixel.g;
        end
        if (we_b)
        begin
            mem[wr_addr].b <= wr_pixel.b;
        end
    end

    // Registered read, one cycle latency
    always_ff @(posedge aclk)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- fb_cfg_pkg.sv
// Framebuffer geometry and pixel formats
// Covers the 16x16 RGB666 store, the RGBA8888 pipeline and the RGB565 stream
`default_nettype none

package fb_cfg_pkg;

    // Screen geometry, fixed at 16 by 16
    localparam int FB_X_BITS = 4;
    localparam int FB_Y_BITS = 4;
    localparam int FB_WORDS  = 2 ** (FB_X_BITS + FB_Y_BITS);

    // Channel widths
    localparam int FB_SUB_PIXEL_WIDTH    = 6;
    localparam int COLOR_SUB_PIXEL_WIDTH = 8;
    localparam int STREAM_PIXEL_WIDTH    = 16;

    // Pixel index, y * 16 + x
    typedef logic [FB_X_BITS + FB_Y_BITS - 1 : 0] fb_addr_t;
    typedef logic [FB_X_BITS - 1 : 0]             screen_pos_t;

    // Pipeline color as delivered by the pixel writes
    typedef struct packed {
        logic [COLOR_SUB_PIXEL_WIDTH - 1 : 0] r;
        logic [COLOR_SUB_PIXEL_WIDTH - 1 : 0] g;
        logic [COLOR_SUB_PIXEL_WIDTH - 1 : 0] b;
        logic [COLOR_SUB_PIXEL_WIDTH - 1 : 0] a;
    } rgba8888_t;

    // Stored word, no alpha channel
    typedef struct packed {
        logic [FB_SUB_PIXEL_WIDTH - 1 : 0] r;
        logic [FB_SUB_PIXEL_WIDTH - 1 : 0] g;
        logic [FB_SUB_PIXEL_WIDTH - 1 : 0] b;
    } fb_pixel_t;

    // Output stream word
    typedef struct packed {
        logic [4 : 0] r;
        logic [5 : 0] g;
        logic [4 : 0] b;
    } rgb565_t;

endpackage

`default_nettype wire

//--- fb_checker.sv
// Scoreboard for the color framebuffer
// Keeps a model of the RGB666 store and compares every accepted RGB565 beat
`timescale 1ns/10ps
`default_nettype none

module fb_checker (
    input  wire                      aclk,
    input  wire                      arst_n,
    input  wire                      cmd_valid,
    input  wire fb_cmd_pkg::fb_cmd_t cmd,
    input  wire                      px_valid,
    input  wire fb_cmd_pkg::fb_wr_t  px,
    input  wire                      busy,
    input  wire                      out_valid,
    input  wire                      out_ready,
    input  wire                      out_last,
    input  wire fb_cfg_pkg::rgb565_t out_data,
    output int                       checks,
    output int                       errors,
    output int                       commits_started,
    output int                       commits_done
);
    import fb_cfg_pkg::*;
    import fb_cmd_pkg::*;

    // Model words hold r, g, b from the top bit down
    logic [17:0] model [256];
    scissor_t    m_scissor;
    logic        m_scissor_en;
    logic [3:0]  m_mask;
    rgba8888_t   m_clear;
    logic        exp_busy = 1'b0;
    int          memset_left = 0;
    int          beat = 0;
    int          commit_errors = 0;
    int          check_cnt = 0;
    int          err_cnt = 0;
    int          start_cnt = 0;
    int          done_cnt = 0;
    rgb565_t     exp_data;
    logic        exp_last;

    assign checks          = check_cnt;
    assign errors          = err_cnt;
    assign commits_started = start_cnt;
    assign commits_done    = done_cnt;

    // End coordinates are exclusive
    function automatic logic in_rect(input int x, input int y);
        if (!m_scissor_en)
        begin
            return 1'b1;
        end
        return x >= m_scissor.start_x && x < m_scissor.end_x
            && y >= m_scissor.start_y && y < m_scissor.end_y;
    endfunction

    // Enabled channels take the top six bits of the pipeline color
    function automatic logic [17:0] blend(input logic [17:0] old, input rgba8888_t c);
        logic [17:0] w;
        w = old;
        if (m_mask[3])
        begin
            w[17:12] = c.r[7:2];
        end
        if (m_mask[2])
        begin
            w[11:6] = c.g[7:2];
        end
        if (m_mask[1])
        begin
            w[5:0] = c.b[7:2];
        end
        return w;
    endfunction

    // Widen to 8 bits by repeating the top two bits, then keep 5, 6 and 5
    function automatic rgb565_t expect_beat(input logic [17:0] w);
        logic [7:0] r8;
        logic [7:0] g8;
        logic [7:0] b8;
        r8 = {w[17:12], w[17:16]};
        g8 = {w[11:6], w[11:10]};
        b8 = {w[5:0], w[5:4]};
        return {r8[7:3], g8[7:2], b8[7:3]};
    endfunction

    always @(posedge aclk)
    begin
        if (!arst_n)
        begin
            m_scissor    = '{8'd0, 8'd0, 8'd16, 8'd16};
            m_scissor_en = 1'b0;
            m_mask       = 4'hF;
            m_clear      = '0;
            exp_busy     = 1'b0;
            memset_left  = 0;
            beat         = 0;
            check_cnt++;
            if (busy || out_valid || out_last)
            begin
                err_cnt++;
                $display("ERROR %0t: busy or stream outputs high while reset is held", $time);
            end
        end
        else
        begin
            // Busy level follows the accepted commands and the stream
            check_cnt++;
            if (busy !== exp_busy)
            begin
                err_cnt++;
                $display("ERROR %0t: busy expected %0b, got %0b", $time, exp_busy, busy);
            end

            if (exp_busy)
            begin
                // Memset keeps busy high for 256 cycles
                if (memset_left > 0)
                begin
                    memset_left--;
                    if (memset_left == 0)
                    begin
                        exp_busy = 1'b0;
                    end
                end
            end
            else
            begin
                // Pixel goes in with the configuration of the cycle before
                if (px_valid && in_rect(px.x, px.y))
                begin
                    model[{px.y, px.x}] = blend(model[{px.y, px.x}], px.color);
                end

                if (cmd_valid)
                begin
                    case (cmd.op)
                        OP_SCISSOR:     m_scissor    = cmd.payload.scissor;
                        OP_SCISSOR_EN:  m_scissor_en = cmd.payload[0];
                        OP_CLEAR_COLOR: m_clear      = cmd.payload.color;
                        OP_COLOR_MASK:  m_mask       = cmd.payload[3:0];
                        OP_MEMSET:
                        begin
                            for (int a = 0; a < 256; a++)
                            begin
                                if (in_rect(a % 16, a / 16))
                                begin
                                    model[a] = blend(model[a], m_clear);
                                end
                            end
                            exp_busy    = 1'b1;
                            memset_left = 256;
                        end
                        OP_COMMIT:
                        begin
                            start_cnt++;
                            beat          = 0;
                            commit_errors = 0;
                            exp_busy      = 1'b1;
                        end
                        default: ;
                    endcase
                end
            end

            if (out_valid && out_ready)
            begin
                exp_data = expect_beat(model[beat[7:0]]);
                exp_last = (beat == 255);
                check_cnt++;
                if (beat > 255)
                begin
                    err_cnt++;
                    commit_errors++;
                    $display("ERROR %0t: more than 256 beats in one commit", $time);
                end
                if (out_data !== exp_data)
                begin
                    err_cnt++;
                    commit_errors++;
                    $display("ERROR %0t: pixel %0d expected %h, got %h",
                             $time, beat, exp_data, out_data);
                end
                if (out_last !== exp_last)
                begin
                    err_cnt++;
                    commit_errors++;
                    $display("ERROR %0t: pixel %0d out_last expected %0b, got %0b",
                             $time, beat, exp_last, out_last);
                end
                beat++;
                if (out_last)
                begin
                    done_cnt++;
                    exp_busy = 1'b0;
                    $display("commit %0d: %0d beats, %0d mismatches",
                             done_cnt, beat, commit_errors);
                    beat = 0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- fb_cmd_ctrl.sv
// Framebuffer command control
// Decodes strobed commands, keeps the configuration and runs memset and commit
`timescale 1ns/10ps
`default_nettype none

module fb_cmd_ctrl (
    input  wire                     aclk,
    input  wire                     arst_n,
    input  wire                     cmd_valid,
    input  wire fb_cmd_pkg::fb_cmd_t cmd,
    input  wire                     px_valid,
    input  wire fb_cmd_pkg::fb_wr_t  px,
    input  wire                     commit_done,
    output fb_cmd_pkg::fb_cfg_t     cfg,
    output fb_cmd_pkg::fb_wr_t      wr,
    output logic                    commit_start,
    output logic                    busy
);
    import fb_cfg_pkg::*;
    import fb_cmd_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MEMSET,
        ST_COMMIT
    } state_e;

    state_e    state;
    rgba8888_t clear_color;
    fb_addr_t  sweep_addr;
    logic      cmd_accept;

    // Nothing is taken while a memset or commit runs
    assign cmd_accept = cmd_valid && (state == ST_IDLE);
    assign busy       = (state != ST_IDLE);

    // Configuration registers
    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cfg.scissor_en <= 1'b0;
            cfg.scissor    <= SCISSOR_RESET;
            cfg.mask       <= MASK_RESET;
            clear_color    <= '0;
        end
        else if (cmd_accept)
        begin
            case (cmd.op)
                OP_SCISSOR:     cfg.scissor    <= cmd.payload.scissor;
                OP_SCISSOR_EN:  cfg.scissor_en <= cmd.payload[0];
                OP_CLEAR_COLOR: clear_color    <= cmd.payload.color;
                OP_COLOR_MASK:  cfg.mask       <= cmd.payload[3:0];
                default:        ;
            endcase
        end
    end

    // Idle, memset sweep and commit
    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state        <= ST_IDLE;
            sweep_addr   <= '0;
            commit_start <= 1'b0;
        end
        else
        begin
            commit_start <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (cmd_accept && (cmd.op == OP_MEMSET))
                    begin
                        state      <= ST_MEMSET;
                        sweep_addr <= '0;
                    end
                    else if (cmd_accept && (cmd.op == OP_COMMIT))
                    begin
                        state        <= ST_COMMIT;
                        commit_start <= 1'b1;
                    end
                end
                ST_MEMSET:
                begin
                    // One word per cycle, 256 cycles in all
                    sweep_addr <= sweep_addr + 1'b1;
                    if (sweep_addr == fb_addr_t'(FB_WORDS - 1))
                    begin
                        state <= ST_IDLE;
                    end
                end
                ST_COMMIT:
                begin
                    if (commit_done)
                    begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Write port owner is the sweep during memset, the pixel pipeline otherwise
    always_comb
    begin
        if (state == ST_MEMSET)
        begin
            wr.valid = 1'b1;
            wr.x     = sweep_addr[FB_X_BITS - 1 : 0];
            wr.y     = sweep_addr[FB_X_BITS +: FB_Y_BITS];
            wr.color = clear_color;
        end
        else
        begin
            wr.valid = px_valid && (state == ST_IDLE);
            wr.x     = px.x;
            wr.y     = px.y;
            wr.color = px.color;
        end
    end

endmodule

`default_nettype wire

//--- fb_cmd_pkg.sv
// Command set of the color framebuffer
// Opcodes, the 32-bit payload with its two views, and the structs passed between blocks
`default_nettype none

package fb_cmd_pkg;

    localparam int SCISSOR_POS_BITS = 8;

    typedef enum logic [2:0] {
        OP_SCISSOR     = 3'd0,
        OP_SCISSOR_EN  = 3'd1,
        OP_CLEAR_COLOR = 3'd2,
        OP_COLOR_MASK  = 3'd3,
        OP_MEMSET      = 3'd4,
        OP_COMMIT      = 3'd5
    } fb_op_e;

    // End coordinates are exclusive
    typedef struct packed {
        logic [SCISSOR_POS_BITS - 1 : 0] start_x;
        logic [SCISSOR_POS_BITS - 1 : 0] start_y;
        logic [SCISSOR_POS_BITS - 1 : 0] end_x;
        logic [SCISSOR_POS_BITS - 1 : 0] end_y;
    } scissor_t;

    // Scissor command reads the rectangle, clear color command reads the color
    typedef union packed {
        scissor_t              scissor;
        fb_cfg_pkg::rgba8888_t color;
    } fb_payload_u;

    typedef struct packed {
        fb_op_e      op;
        fb_payload_u payload;
    } fb_cmd_t;

    // Same channel order as the payload, bit 3 is red
    typedef struct packed {
        logic r;
        logic g;
        logic b;
        logic a;
    } color_mask_t;

    typedef struct packed {
        logic        scissor_en;
        scissor_t    scissor;
        color_mask_t mask;
    } fb_cfg_t;

    typedef struct packed {
        logic                    valid;
        fb_cfg_pkg::screen_pos_t x;
        fb_cfg_pkg::screen_pos_t y;
        fb_cfg_pkg::rgba8888_t   color;
    } fb_wr_t;

    // Full screen rectangle
    localparam scissor_t SCISSOR_RESET = '{
        start_x: '0,
        start_y: '0,
        end_x:   SCISSOR_POS_BITS'(2 ** fb_cfg_pkg::FB_X_BITS),
        end_y:   SCISSOR_POS_BITS'(2 ** fb_cfg_pkg::FB_Y_BITS)
    };

    localparam color_mask_t MASK_RESET = '1;

endpackage

`default_nettype wire

//--- fb_top.sv
// Color framebuffer top level
// Command control, pixel store and RGB565 read-out stream
`timescale 1ns/10ps
`default_nettype none

module fb_top (
    input  wire                      aclk,
    input  wire                      arst_n,

    // Strobed commands
    input  wire                      cmd_valid,
    input  wire fb_cmd_pkg::fb_cmd_t cmd,

    // Pixel writes, the valid field of px is not used
    input  wire                      px_valid,
    input  wire fb_cmd_pkg::fb_wr_t  px,

    output logic                     busy,

    // RGB565 output stream
    output logic                     out_valid,
    input  wire                      out_ready,
    output logic                     out_last,
    output fb_cfg_pkg::rgb565_t      out_data
);
    import fb_cfg_pkg::*;
    import fb_cmd_pkg::*;

    fb_cfg_t   cfg;
    fb_wr_t    wr;
    logic      commit_start;
    logic      commit_done;
    fb_addr_t  rd_addr;
    fb_pixel_t rd_data;

    fb_cmd_ctrl i_fb_cmd_ctrl (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .px_valid     (px_valid),
        .px           (px),
        .commit_done  (commit_done),
        .cfg          (cfg),
        .wr           (wr),
        .commit_start (commit_start),
        .busy         (busy)
    );

    color_store i_color_store (
        .aclk    (aclk),
        .cfg     (cfg),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    stream_out i_stream_out (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .commit_start (commit_start),
        .rd_data      (rd_data),
        .out_ready    (out_ready),
        .rd_addr      (rd_addr),
        .commit_done  (commit_done),
        .out_valid    (out_valid),
        .out_last     (out_last),
        .out_data     (out_data)
    );

endmodule

`default_nettype wire

//--- fb_top_sva.sv
// Bound assertions on the framebuffer top level
// Reset state and protocol of the RGB565 output stream
`timescale 1ns/10ps
`default_nettype none

module fb_top_sva (
    input wire                      aclk,
    input wire                      arst_n,
    input wire                      busy,
    input wire                      out_valid,
    input wire                      out_ready,
    input wire                      out_last,
    input wire fb_cfg_pkg::rgb565_t out_data
);

    // Control outputs stay quiet while reset is held
    a_reset_quiet: assert property (@(posedge aclk)
        !arst_n |-> (!busy && !out_valid && !out_last))
        else $error("busy, out_valid or out_last high during reset");

    // A stalled beat keeps its data until it is taken
    a_hold_data: assert property (@(posedge aclk) disable iff (!arst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else $error("out_data changed or beat dropped under back-pressure");

    a_last_valid: assert property (@(posedge aclk) disable iff (!arst_n)
        out_last |-> out_valid)
        else $error("out_last high without out_valid");

endmodule

bind fb_top fb_top_sva i_fb_top_sva (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .busy      (busy),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_last  (out_last),
    .out_data  (out_data)
);

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the framebuffer testbench with Verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1

TOP=tb_fb_top
LOG=sim.log

rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal --top-module "$TOP" -f sources.f \
    -o "$TOP" > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

# An assertion stop ends the run with a non-zero status
./obj_dir/"$TOP" > "$LOG" 2>&1 || echo "sim failed" >> "$LOG"

cat "$LOG"

grep -q "sim failed" "$LOG" && { echo "FAIL"; exit 1; }
grep -q "sim passed" "$LOG" && { echo "PASS"; exit 0; }
echo "FAIL: no result line in $LOG"
exit 1

//--- sources.f
fb_cfg_pkg.sv
fb_cmd_pkg.sv
fb_cmd_ctrl.sv
color_store.sv
stream_out.sv
fb_top.sv
fb_top_sva.sv
fb_checker.sv
tb_fb_top.sv

//--- stream_out.sv
// Framebuffer read-out
// Streams all 256 words as RGB565 with valid/ready, one read in flight plus a hold slot
`timescale 1ns/10ps
`default_nettype none

module stream_out (
    input  wire                        aclk,
    input  wire                        arst_n,
    input  wire                        commit_start,
    input  wire fb_cfg_pkg::fb_pixel_t rd_data,
    input  wire                        out_ready,
    output fb_cfg_pkg::fb_addr_t       rd_addr,
    output logic                       commit_done,
    output logic                       out_valid,
    output logic                       out_last,
    output fb_cfg_pkg::rgb565_t        out_data
);
    import fb_cfg_pkg::*;

    logic       rd_active;
    logic       rd_issue;
    logic       rd_pend;
    logic       rd_pend_last;
    logic       hold_valid;
    logic       hold_last;
    logic       out_pop;
    logic       out_free;
    logic [1:0] occupancy;
    rgb565_t    rd_pixel;
    rgb565_t    hold_data;

    // Repeat the top bits into the new low bits
    function automatic logic [COLOR_SUB_PIXEL_WIDTH - 1 : 0] expand(
        input logic [FB_SUB_PIXEL_WIDTH - 1 : 0] v
    );
        return {v, v[FB_SUB_PIXEL_WIDTH - 1 -: COLOR_SUB_PIXEL_WIDTH - FB_SUB_PIXEL_WIDTH]};
    endfunction

    function automatic rgb565_t to_rgb565(input fb_pixel_t p);
        logic [COLOR_SUB_PIXEL_WIDTH - 1 : 0] r8;
        logic [COLOR_SUB_PIXEL_WIDTH - 1 : 0] g8;
        logic [COLOR_SUB_PIXEL_WIDTH - 1 : 0] b8;
        rgb565_t                              o;
        r8  = expand(p.r);
        g8  = expand(p.g);
        b8  = expand(p.b);
        o.r = r8[COLOR_SUB_PIXEL_WIDTH - 1 -: 5];
        o.g = g8[COLOR_SUB_PIXEL_WIDTH - 1 -: 6];
        o.b = b8[COLOR_SUB_PIXEL_WIDTH - 1 -: 5];
        return o;
    endfunction

    assign rd_pixel    = to_rgb565(rd_data);
    assign out_pop     = out_valid && out_ready;
    assign out_free    = !out_valid || out_ready;
    assign commit_done = out_pop && out_last;

    // Output, hold and in-flight read never exceed the two slots
    assign occupancy = 2'(out_valid) + 2'(hold_valid) + 2'(rd_pend);
    assign rd_issue  = rd_active && ((occupancy - 2'(out_pop)) < 2'd2);

    // Read address counter
    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rd_active    <= 1'b0;
            rd_addr      <= '0;
            rd_pend      <= 1'b0;
            rd_pend_last <= 1'b0;
        end
        else
        begin
            rd_pend      <= rd_issue;
            rd_pend_last <= rd_issue && (rd_addr == fb_addr_t'(FB_WORDS - 1));
            if (commit_start)
            begin
                rd_active <= 1'b1;
                rd_addr   <= '0;
            end
            else if (rd_issue)
            begin
                rd_addr <= rd_addr + 1'b1;
                if (rd_addr == fb_addr_t'(FB_WORDS - 1))
                begin
                    rd_active <= 1'b0;
                end
            end
        end
    end

    // Output and hold slot flags
    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            out_valid  <= 1'b0;
            out_last   <= 1'b0;
            hold_valid <= 1'b0;
            hold_last  <= 1'b0;
        end
        else if (out_free)
        begin
            if (hold_valid)
            begin
                out_valid  <= 1'b1;
                out_last   <= hold_last;
                hold_valid <= rd_pend;
                hold_last  <= rd_pend_last;
            end
            else
            begin
                out_valid <= rd_pend;
                out_last  <= rd_pend_last;
            end
        end
        else if (rd_pend)
        begin
            // Stalled beat, the arriving word waits in the hold slot
            hold_valid <= 1'b1;
            hold_last  <= rd_pend_last;
        end
    end

    // Beat data follows the same moves as the flags
    always_ff @(posedge aclk)
    begin
        if (out_free)
        begin
            if (hold_valid)
            begin
                out_data  <= hold_data;
                hold_data <= rd_pixel;
            end
            else
            begin
                out_data <= rd_pixel;
            end
        end
        else if (rd_pend)
        begin
            hold_data <= rd_pixel;
        end
    end

endmodule

`default_nettype wire

//--- tb_fb_top.sv
// Testbench for the color framebuffer
// Table-driven commands and pixel writes with random back-pressure and a watchdog
`timescale 1ns/10ps
`default_nettype none

module tb_fb_top;
    import fb_cfg_pkg::*;
    import fb_cmd_pkg::*;

    typedef enum logic [2:0] {
        K_CMD,
        K_NOWAIT,
        K_PX,
        K_WAIT,
        K_READY
    } kind_e;

    typedef struct packed {
        kind_e       kind;
        fb_op_e      op;
        logic [31:0] payload;
        screen_pos_t x;
        screen_pos_t y;
    } row_t;

    localparam int NUM_ROWS        = 41;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 1400 + 100;

    // Scissor payload is start_x, start_y, end_x, end_y from the top byte down
    localparam row_t ROWS [NUM_ROWS] = '{
        '{K_CMD,    OP_CLEAR_COLOR, 32'hC8643CFF, 4'd0,  4'd0},
        '{K_CMD,    OP_MEMSET,      32'h00000000, 4'd0,  4'd0},
        '{K_CMD,    OP_COMMIT,      32'h00000000, 4'd0,  4'd0},
        '{K_CMD,    OP_CLEAR_COLOR, 32'h10F08000, 4'd0,  4'd0},
        '{K_CMD,    OP_SCISSOR,     32'h03020B07, 4'd0,  4'd0},
        '{K_CMD,    OP_SCISSOR_EN,  32'h00000001, 4'd0,  4'd0},
        '{K_CMD,    OP_MEMSET,      32'h00000000, 4'd0,  4'd0},
        '{K_CMD,    OP_COMMIT,      32'h00000000, 4'd0,  4'd0},
        '{K_PX,     OP_SCISSOR,     32'h00000000, 4'd1,  4'd1},
        '{K_PX,     OP_SCISSOR,     32'h00000000, 4'd4,  4'd3},
        '{K_PX,     OP_SCISSOR,     32'h00000000, 4'd10, 4'd6},
        '{K_PX,     OP_SCISSOR,     32'h00000000, 4'd11, 4'd6},
        '{K_PX,     OP_SCISSOR,     32'h00000000, 4'd3,  4'd7},
        '{K_CMD,    OP_SCISSOR_EN,  32'h00000000, 4'd0,  4'd0},
        '{K_PX,     OP_SCISSOR,     32'h00000000, 4'd0,  4'd0},
        '{K_PX,     OP_SCISSOR,     32'h00000000, 4'd15, 4'd15},
        '{K_PX,     OP_SCISSOR,     32'h00000000, 4'd7,  4'd12},
        '{K_READY,  OP_SCISSOR,     32'h00000001, 4'd0,  4'd0},
        '{K_CMD,    OP_COMMIT,      32'h00000000, 4'd0,  4'd0},
        '{K_CMD,    OP_COLOR_MASK,  32'h00000004, 4'd0,  4'd0},
        '{K_CMD,    OP_CLEAR_COLOR, 32'hFFFFFFFF, 4'd0,  4'd0},
        '{K_CMD,    OP_MEMSET,      32'h00000000, 4'd0,  4'd0},
        '{K_PX,     OP_SCISSOR,     32'h00000000, 4'd5,  4'd5},
        '{K_PX,     OP_SCISSOR,     32'h00000000, 4'd9,  4'd2},
        '{K_CMD,    OP_COMMIT,      32'h00000000, 4'd0,  4'd0},
        '{K_CMD,    OP_COLOR_MASK,  32'h0000000F, 4'd0,  4'd0},
        '{K_CMD,    OP_CLEAR_COLOR, 32'h20406000, 4'd0,  4'd0},
        '{K_NOWAIT, OP_MEMSET,      32'h00000000, 4'd0,  4'd0},
        '{K_CMD,    OP_CLEAR_COLOR, 32'hFF00FF00, 4'd0,  4'd0},
        '{K_PX,     OP_SCISSOR,     32'h00000000, 4'd3,  4'd3},
        '{K_CMD,    OP_COLOR_MASK,  32'h00000000, 4'd0,  4'd0},
        '{K_CMD,    OP_COMMIT,      32'h00000000, 4'd0,  4'd0},
        '{K_WAIT,   OP_SCISSOR,     32'h00000000, 4'd0,  4'd0},
        '{K_PX,     OP_SCISSOR,     32'h00000000, 4'd6,  4'd6},
        '{K_CMD,    OP_COMMIT,      32'h00000000, 4'd0,  4'd0},
        '{K_NOWAIT, OP_COMMIT,      32'h00000000, 4'd0,  4'd0},
        '{K_PX,     OP_SCISSOR,     32'h00000000, 4'd8,  4'd8},
        '{K_CMD,    OP_MEMSET,      32'h00000000, 4'd0,  4'd0},
        '{K_WAIT,   OP_SCISSOR,     32'h00000000, 4'd0,  4'd0},
        '{K_READY,  OP_SCISSOR,     32'h00000000, 4'd0,  4'd0},
        '{K_CMD,    OP_COMMIT,      32'h00000000, 4'd0,  4'd0}
    };

    logic        aclk;
    logic        arst_n;
    logic        cmd_valid;
    fb_cmd_t     cmd;
    logic        px_valid;
    fb_wr_t      px;
    logic        busy;
    logic        out_valid;
    logic        out_ready;
    logic        out_last;
    rgb565_t     out_data;
    logic        random_ready;
    logic [31:0] px_rng;
    logic [31:0] rdy_rng;
    int          checks;
    int          errors;
    int          commits_started;
    int          commits_done;

    fb_top i_fb_top (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .px_valid  (px_valid),
        .px        (px),
        .busy      (busy),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_last  (out_last),
        .out_data  (out_data)
    );

    fb_checker i_fb_checker (
        .aclk            (aclk),
        .arst_n          (arst_n),
        .cmd_valid       (cmd_valid),
        .cmd             (cmd),
        .px_valid        (px_valid),
        .px              (px),
        .busy            (busy),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_last        (out_last),
        .out_data        (out_data),
        .checks          (checks),
        .errors          (errors),
        .commits_started (commits_started),
        .commits_done    (commits_done)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic send_cmd(input fb_op_e op, input logic [31:0] payload);
        @(posedge aclk);
        cmd_valid   <= 1'b1;
        cmd.op      <= op;
        cmd.payload <= payload;
        @(posedge aclk);
        cmd_valid <= 1'b0;
    endtask

    task automatic write_pixel(input screen_pos_t x, input screen_pos_t y);
        px_rng = xorshift(px_rng);
        @(posedge aclk);
        px_valid <= 1'b1;
        px.x     <= x;
        px.y     <= y;
        px.color <= px_rng;
        @(posedge aclk);
        px_valid <= 1'b0;
    endtask

    // Busy is sampled away from the active edge
    task automatic wait_idle();
        @(negedge aclk);
        while (busy)
        begin
            @(negedge aclk);
        end
    endtask

    initial
    begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    // Sink back-pressure, ready about three beats in four when random
    initial
    begin
        out_ready = 1'b1;
        rdy_rng   = 32'd61269;
        forever
        begin
            @(posedge aclk);
            out_ready <= random_ready ? (rdy_rng[2:1] != 2'b00) : 1'b1;
            rdy_rng   <= xorshift(rdy_rng);
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

    initial
    begin
        arst_n       = 1'b0;
        cmd_valid    = 1'b0;
        cmd          = '0;
        px_valid     = 1'b0;
        px           = '0;
        random_ready = 1'b0;
        px_rng       = 32'd61269;
        repeat (8) @(posedge aclk);
        arst_n <= 1'b1;

        for (int i = 0; i < NUM_ROWS; i++)
        begin
            case (ROWS[i].kind)
                K_CMD:
                begin
                    send_cmd(ROWS[i].op, ROWS[i].payload);
                    if (ROWS[i].op == OP_MEMSET || ROWS[i].op == OP_COMMIT)
                    begin
                        wait_idle();
                    end
                end
                K_NOWAIT: send_cmd(ROWS[i].op, ROWS[i].payload);
                K_PX:     write_pixel(ROWS[i].x, ROWS[i].y);
                K_WAIT:   wait_idle();
                K_READY:
                begin
                    @(posedge aclk);
                    random_ready <= ROWS[i].payload[0];
                end
                default: ;
            endcase
        end

        repeat (4) @(posedge aclk);
        $display("summary: %0d checks, %0d errors, %0d of %0d commits completed",
                 checks, errors, commits_done, commits_started);
        if (errors == 0 && commits_done == commits_started && commits_done > 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
